// File: rtl/control.sv
`timescale 1ns/100ps

module control import riscv::*; (
    input  logic    clk,
    input  logic    resetn,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  funct7_t funct7,
    output ctrl_t   ctrl
);
    typedef enum logic {JMP_NONE, JMP_JAL} jmp_t;

    typedef struct packed {
        logic     reg_en;
        mem_op_t  mem_op;
        logic     link_en;
        alu_op_t  alu_op;
        jmp_t     jmp;
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
    } ctrl_id_t;

    typedef struct packed {
        logic    reg_en;
        mem_op_t mem_op;
        logic    link_en;
        alu_op_t alu_op;
        jmp_t    jmp;
    } ctrl_ex_t;

    typedef struct packed {
        logic    reg_en;
        mem_op_t mem_op;
    } ctrl_mem_t;

    // Decode table
    localparam ctrl_id_t CTRL_INVALID = '{1'b0, NONE, 1'b0, ALU_ADD, JMP_NONE, OP1_RS1, OP2_RS2};
    localparam ctrl_id_t CTRL_ADDI    = '{1'b1, NONE, 1'b0, ALU_ADD, JMP_NONE, OP1_RS1, OP2_I_IMM};
    localparam ctrl_id_t CTRL_LUI     = '{1'b1, NONE, 1'b0, ALU_OP2, JMP_NONE, OP1_RS1, OP2_U_IMM};
    localparam ctrl_id_t CTRL_AUIPC   = '{1'b1, NONE, 1'b0, ALU_ADD, JMP_NONE, OP1_PC, OP2_U_IMM};
    localparam ctrl_id_t CTRL_ADD     = '{1'b1, NONE, 1'b0, ALU_ADD, JMP_NONE, OP1_RS1, OP2_RS2};
    localparam ctrl_id_t CTRL_SUB     = '{1'b1, NONE, 1'b0, ALU_SUB, JMP_NONE, OP1_RS1, OP2_RS2};
    localparam ctrl_id_t CTRL_JAL     = '{1'b1, NONE, 1'b1, ALU_ADD, JMP_JAL, OP1_PC, OP2_J_IMM};

    ctrl_id_t  id;
    ctrl_ex_t  ex;
    ctrl_mem_t mem;
    logic      jump;

    always_comb begin
        id = CTRL_INVALID;
        case (opcode)
            OPCODE_OP_IMM: begin
                if (funct3 == FUNCT3_ADDI) begin
                    id = CTRL_ADDI;
                end
            end
            OPCODE_OP: begin
                if (funct3 == FUNCT3_ADD_SUB) begin
                    id = funct7[5] ? CTRL_SUB : CTRL_ADD;
                end
            end
            OPCODE_LUI:   id = CTRL_LUI;
            OPCODE_AUIPC: id = CTRL_AUIPC;
            OPCODE_JAL:   id = CTRL_JAL;
            default:      id = CTRL_INVALID;
        endcase
    end

    // JAL resolves in execute
    assign jump = (ex.jmp == JMP_JAL);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex <= '{1'b0, NONE, 1'b0, ALU_ADD, JMP_NONE};
        end else begin
            // Younger instruction leaving decode is squashed
            ex.reg_en  <= jump ? 1'b0 : id.reg_en;
            ex.mem_op  <= jump ? NONE : id.mem_op;
            ex.jmp     <= jump ? JMP_NONE : id.jmp;
            ex.link_en <= id.link_en;
            ex.alu_op  <= id.alu_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem <= '{1'b0, NONE};
        end else begin
            mem.reg_en <= ex.reg_en;
            mem.mem_op <= ex.mem_op;
        end
    end

    // Write enable leaves in memory, datapath carries it into writeback
    assign ctrl.reg_en  = mem.reg_en;
    assign ctrl.mem_op  = mem.mem_op;
    assign ctrl.link_en = ex.link_en;
    assign ctrl.alu_op  = ex.alu_op;
    assign ctrl.pc_sel  = jump ? PC_ADDR : PC_NEXT;
    assign ctrl.ir_sel  = jump ? IR_BUBBLE : IR_MEMORY;
    assign ctrl.op1_sel = id.op1_sel;
    assign ctrl.op2_sel = id.op2_sel;

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/100ps

module cpu_top import riscv::*; (
    input  logic    clk,
    input  logic    resetn,
    output word_t   instr_addr,
    input  word_t   instr_data,
    output retire_t retire
);
    ctrl_t     ctrl;
    word_t     jump_target;
    word_t     ir;
    word_t     id_pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rf_we;
    reg_addr_t rf_rd;
    word_t     rf_data;

    control control_inst (
        .clk    (clk),
        .resetn (resetn),
        .opcode (opcode_t'(ir[6:0])),
        .funct3 (funct3_t'(ir[14:12])),
        .funct7 (ir[31:25]),
        .ctrl   (ctrl)
    );

    fetch fetch_inst (
        .clk         (clk),
        .resetn      (resetn),
        .ctrl        (ctrl),
        .jump_target (jump_target),
        .instr_data  (instr_data),
        .instr_addr  (instr_addr),
        .ir          (ir),
        .id_pc       (id_pc)
    );

    regfile regfile_inst (
        .clk      (clk),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (rf_rd),
        .rd_data  (rf_data)
    );

    datapath datapath_inst (
        .clk         (clk),
        .resetn      (resetn),
        .ctrl        (ctrl),
        .ir          (ir),
        .id_pc       (id_pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .jump_target (jump_target),
        .rf_we       (rf_we),
        .rf_rd       (rf_rd),
        .rf_data     (rf_data),
        .retire      (retire)
    );

endmodule

// File: rtl/datapath.sv
`timescale 1ns/100ps

module datapath import riscv::*; (
    input  logic      clk,
    input  logic      resetn,
    input  ctrl_t     ctrl,
    input  word_t     ir,
    input  word_t     id_pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output word_t     jump_target,
    output logic      rf_we,
    output reg_addr_t rf_rd,
    output word_t     rf_data,
    output retire_t   retire
);
    reg_addr_t id_rd;
    word_t     imm_i;
    word_t     imm_u;
    word_t     imm_j;
    word_t     id_op1;
    word_t     id_op2;

    word_t     ex_op1;
    word_t     ex_op2;
    word_t     ex_pc;
    reg_addr_t ex_src1;
    reg_addr_t ex_src2;
    reg_addr_t ex_rd;
    word_t     fwd_op1;
    word_t     fwd_op2;
    word_t     alu_result;
    word_t     ex_result;

    reg_addr_t mem_rd;
    word_t     mem_data;

    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Decode
    assign rs1   = ir[19:15];
    assign rs2   = ir[24:20];
    assign id_rd = ir[11:7];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    assign id_op1 = (ctrl.op1_sel == OP1_PC) ? id_pc : rs1_data;

    always_comb begin
        case (ctrl.op2_sel)
            OP2_I_IMM: id_op2 = imm_i;
            OP2_U_IMM: id_op2 = imm_u;
            OP2_J_IMM: id_op2 = imm_j;
            default:   id_op2 = rs2_data;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_op1  <= id_op1;
        ex_op2  <= id_op2;
        ex_pc   <= id_pc;
        ex_rd   <= id_rd;
        // Source tags only for operands read from registers
        ex_src1 <= (ctrl.op1_sel == OP1_RS1) ? rs1 : '0;
        ex_src2 <= (ctrl.op2_sel == OP2_RS2) ? rs2 : '0;
    end

    // Execute forwarding prefers the newest result
    function automatic word_t forward(reg_addr_t src, word_t value);
        word_t result;
        if (src != '0 && ctrl.reg_en && src == mem_rd) begin
            result = mem_data;
        end else if (src != '0 && wb_we && src == wb_rd) begin
            result = wb_data;
        end else begin
            result = value;
        end
        return result;
    endfunction

    always_comb begin
        fwd_op1 = forward(ex_src1, ex_op1);
        fwd_op2 = forward(ex_src2, ex_op2);
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB: alu_result = fwd_op1 - fwd_op2;
            ALU_OP2: alu_result = fwd_op2;
            default: alu_result = fwd_op1 + fwd_op2;
        endcase
    end

    assign jump_target = alu_result;
    assign ex_result   = ctrl.link_en ? ex_pc + 32'd4 : alu_result;

    // Memory stage only delays the result
    always_ff @(posedge clk) begin
        mem_rd   <= ex_rd;
        mem_data <= ex_result;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ctrl.reg_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_data;
    end

    assign rf_we   = wb_we;
    assign rf_rd   = wb_rd;
    assign rf_data = wb_data;

    assign retire = '{valid: wb_we && wb_rd != '0, rd: wb_rd, data: wb_data};

endmodule

// File: rtl/fetch.sv
`timescale 1ns/100ps

`include "riscv_cfg.svh"

module fetch import riscv::*; (
    input  logic  clk,
    input  logic  resetn,
    input  ctrl_t ctrl,
    input  word_t jump_target,
    input  word_t instr_data,
    output word_t instr_addr,
    output word_t ir,
    output word_t id_pc
);
    word_t pc;

    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `RESET_PC;
            ir <= `NOP_INSTR;
        end else begin
            pc <= (ctrl.pc_sel == PC_ADDR) ? jump_target : pc + 32'd4;
            // Drop the wrong-path word on a taken jump
            ir <= (ctrl.ir_sel == IR_BUBBLE) ? `NOP_INSTR : instr_data;
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= pc;
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/100ps

`include "riscv_cfg.svh"

module regfile import riscv::*; (
    input  logic      clk,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     rd_data
);
    word_t regs [`NREGS];

    // x0 reads zero and a same-cycle write passes through
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (we && addr == rd) begin
            value = rd_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

// File: rtl/riscv.sv
`include "riscv_cfg.svh"

package riscv;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_addr_t;

    typedef enum logic [6:0] {
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        FUNCT3_ADD_SUB = 3'b000
    } funct3_t;

    // ADDI shares the ADD/SUB funct3 encoding
    localparam funct3_t FUNCT3_ADDI = FUNCT3_ADD_SUB;

    typedef logic [6:0] funct7_t;

    typedef enum logic [1:0] {NONE, LOAD, STORE} mem_op_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OP2} alu_op_t;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_t;

    typedef enum logic [1:0] {OP2_RS2, OP2_I_IMM, OP2_U_IMM, OP2_J_IMM} op2_sel_t;

    typedef enum logic {PC_NEXT, PC_ADDR} pc_sel_t;

    typedef enum logic {IR_MEMORY, IR_BUBBLE} ir_sel_t;

    // Control word, fields valid in different stages
    typedef struct packed {
        logic     reg_en;
        mem_op_t  mem_op;
        logic     link_en;
        alu_op_t  alu_op;
        pc_sel_t  pc_sel;
        ir_sel_t  ir_sel;
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
    } ctrl_t;

    // Writeback observation record
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

// File: rtl/riscv_cfg.svh
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// Data and address width
`define XLEN 32

`define NREGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0, used as pipeline bubble
`define NOP_INSTR 32'h0000_0013

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_cpu -f sim.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

// File: sim.f
+incdir+rtl
rtl/riscv.sv
rtl/control.sv
rtl/fetch.sv
rtl/regfile.sv
rtl/datapath.sv
rtl/cpu_top.sv
tb/tb_cpu.sv

// File: tb/tb_cpu.sv
`timescale 1ns/100ps

`include "riscv_cfg.svh"

module tb_cpu import riscv::*; ();

    localparam logic [31:0] SEED       = 32'h3645_7ad9;
    localparam int          MEM_WORDS  = 256;
    localparam int          BODY_WORDS = 240;
    // JAL x0, 0 parks the core at the end of the program
    localparam logic [31:0] SELF_JUMP  = 32'h0000_006f;

    logic    clk;
    logic    resetn;
    word_t   instr_addr;
    word_t   instr_data;
    retire_t retire;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] rng_state;
    retire_t     exp_q [$];
    int          executed;

    cpu_top cpu_top_inst (
        .clk        (clk),
        .resetn     (resetn),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .retire     (retire)
    );

    // Instruction memory answers in the same cycle
    assign instr_data = imem[instr_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Only x0..x7, so dependencies come often
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_random();
        return {2'b00, r[2:0]};
    endfunction

    function automatic logic [31:0] encode_addi(logic [4:0] rd, logic [4:0] rs1,
                                                logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_rtype(logic [6:0] funct7, logic [4:0] rd,
                                                 logic [4:0] rs1, logic [4:0] rs2);
        return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_utype(logic [6:0] opcode, logic [4:0] rd,
                                                 logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_jal(logic [4:0] rd, logic [20:0] offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] invalid_word();
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        r = next_random();
        s = next_random();
        f3 = (s[2:0] == 3'b000) ? 3'b001 : s[2:0];
        // Either a load opcode or an OP-IMM funct3 other than ADDI
        if (s[3]) begin
            return {r[31:7], 7'b0000011};
        end
        return {r[31:15], f3, r[11:7], 7'b0010011};
    endfunction

    task automatic build_program();
        int          kind;
        int          hop;
        logic [31:0] r;
        for (int i = 0; i < 7; i++) begin
            r = next_random();
            imem[i] = encode_addi(5'(i + 1), 5'd0, r[11:0]);
        end
        for (int p = 7; p < BODY_WORDS; p++) begin
            kind = int'(next_random() % 32'd24);
            r = next_random();
            if (kind < 2) begin
                hop = 2 + int'(next_random() % 32'd5);
                imem[p] = encode_jal(pick_reg(), 21'(hop * 4));
            end else if (kind == 2) begin
                imem[p] = invalid_word();
            end else if (kind < 7) begin
                imem[p] = encode_addi(pick_reg(), pick_reg(), r[11:0]);
            end else if (kind < 11) begin
                imem[p] = encode_rtype(7'b0000000, pick_reg(), pick_reg(), pick_reg());
            end else if (kind < 15) begin
                imem[p] = encode_rtype(7'b0100000, pick_reg(), pick_reg(), pick_reg());
            end else if (kind < 19) begin
                imem[p] = encode_utype(7'b0110111, pick_reg(), r[31:12]);
            end else begin
                imem[p] = encode_utype(7'b0010111, pick_reg(), r[31:12]);
            end
        end
        for (int p = BODY_WORDS; p < MEM_WORDS - 1; p++) begin
            imem[p] = `NOP_INSTR;
        end
        imem[MEM_WORDS - 1] = SELF_JUMP;
    endtask

    // ISA reference, fills the expected retire stream
    task automatic run_model();
        logic [31:0] xr [32];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] value;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        write;
        retire_t     rec;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        pc = `RESET_PC;
        executed = 0;
        while (imem[pc[9:2]] != SELF_JUMP && executed < 4096) begin
            instr = imem[pc[9:2]];
            rd = instr[11:7];
            rs1 = instr[19:15];
            rs2 = instr[24:20];
            value = '0;
            write = 1'b1;
            next_pc = pc + 32'd4;
            case (instr[6:0])
                7'b0010011: begin
                    write = (instr[14:12] == 3'b000);
                    value = xr[rs1] + {{20{instr[31]}}, instr[31:20]};
                end
                7'b0110011: begin
                    write = (instr[14:12] == 3'b000);
                    value = instr[30] ? xr[rs1] - xr[rs2] : xr[rs1] + xr[rs2];
                end
                7'b0110111: value = {instr[31:12], 12'b0};
                7'b0010111: value = pc + {instr[31:12], 12'b0};
                7'b1101111: begin
                    value = pc + 32'd4;
                    next_pc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                    instr[30:21], 1'b0};
                end
                default: write = 1'b0;
            endcase
            if (write && rd != 5'd0) begin
                xr[rd] = value;
                rec.valid = 1'b1;
                rec.rd = rd;
                rec.data = value;
                exp_q.push_back(rec);
            end
            executed++;
            pc = next_pc;
        end
    endtask

    task automatic report_failure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(negedge clk) begin : retire_monitor
        retire_t expected;
        if (resetn && retire.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("[ERROR] %0t: unexpected retire x%0d = %h after the last expected one",
                         $time, retire.rd, retire.data);
                report_failure();
            end
            expected = exp_q.pop_front();
            assert (retire == expected) else begin
                $display("[ERROR] %0t: retire expected x%0d = %h, got x%0d = %h",
                         $time, expected.rd, expected.data, retire.rd, retire.data);
                report_failure();
            end
        end
    end

    initial begin : main_sequence
        int limit;
        int cycle;
        resetn = 1'b0;
        rng_state = SEED;
        build_program();
        run_model();
        limit = 4 * executed + 200;
        $display("Model executed %0d instructions, %0d retirements expected",
                 executed, exp_q.size());

        repeat (5) @(posedge clk);
        #1 resetn = 1'b1;

        // First word takes four edges to reach writeback
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (i == 0) begin
                assert (instr_addr == `RESET_PC) else begin
                    $display("[ERROR] %0t: instr_addr after reset is %h, expected %h",
                             $time, instr_addr, `RESET_PC);
                    report_failure();
                end
            end
            assert (!retire.valid) else begin
                $display("[ERROR] %0t: retire valid before the pipeline filled", $time);
                report_failure();
            end
        end

        cycle = 4;
        while (exp_q.size() != 0 && cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        // Quiet window, the monitor flags any extra retire
        repeat (20) @(posedge clk);

        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Timeout after %0d cycles: %0d expected retirements never arrived",
                     cycle, exp_q.size());
            report_failure();
        end
    end

endmodule
